//--- asteroid_game.sv
`timescale 1ns/1ns

module asteroid_game #(
    parameter int LIVES_INIT   = 3,
    parameter int MAX_DISTANCE = 15,
    parameter int STEP_CYCLES  = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      shot,
    input  asteroid_pkg::lane_t       shot_lane,
    output asteroid_pkg::asteroid_t   asteroid,
    output asteroid_pkg::status_t     status,
    output logic                      game_over,
    output asteroid_pkg::game_state_e state
);

    asteroid_pkg::control_t control;
    logic                   collision;
    logic                   hit;
    logic                   lives_left;

    game_control game_control_i (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .shot       (shot),
        .collision  (collision),
        .hit        (hit),
        .lives_left (lives_left),
        .control    (control),
        .state      (state),
        .game_over  (game_over)
    );

    asteroid_tracker #(
        .MAX_DISTANCE (MAX_DISTANCE),
        .STEP_CYCLES  (STEP_CYCLES)
    ) asteroid_tracker_i (
        .clock     (clock),
        .reset     (reset),
        .control   (control),
        .asteroid  (asteroid),
        .collision (collision)
    );

    shot_judge shot_judge_i (
        .clock     (clock),
        .reset     (reset),
        .control   (control),
        .shot_lane (shot_lane),
        .asteroid  (asteroid),
        .hit       (hit)
    );

    player_status #(
        .LIVES_INIT (LIVES_INIT)
    ) player_status_i (
        .clock      (clock),
        .reset      (reset),
        .control    (control),
        .status     (status),
        .lives_left (lives_left)
    );

endmodule

//--- asteroid_game_properties.sv
`timescale 1ns/1ns

module asteroid_game_properties #(
    parameter int LIVES_INIT = 3
) (
    input logic                   clock,
    input logic                   reset,
    input asteroid_pkg::control_t control,
    input asteroid_pkg::status_t  status,
    input logic                   game_over
);

    int unsigned failure_count = 0;

    // at most one datapath action per cycle
    one_action: assert property (@(posedge clock) disable iff (reset)
        $onehot0({control.spawn, control.lose_life, control.destroy}))
        else begin
            $error("more than one of spawn, lose_life and destroy active");
            failure_count++;
        end

    lives_bounded: assert property (@(posedge clock) disable iff (reset)
        status.lives <= LIVES_INIT)
        else begin
            $error("lives above the initial count");
            failure_count++;
        end

    over_means_no_lives: assert property (@(posedge clock) disable iff (reset)
        game_over |-> (status.lives == '0))
        else begin
            $error("game over with lives remaining");
            failure_count++;
        end

endmodule

bind asteroid_game asteroid_game_properties #(
    .LIVES_INIT (LIVES_INIT)
) asteroid_game_properties_i (
    .clock     (clock),
    .reset     (reset),
    .control   (control),
    .status    (status),
    .game_over (game_over)
);

//--- asteroid_pkg.sv
package asteroid_pkg;

    // meaningful widths
    typedef logic [2:0] lane_t;      // eight lanes
    typedef logic [3:0] distance_t;  // steps from the ship
    typedef logic [2:0] lives_t;
    typedef logic [7:0] score_t;     // wraps at 255

    typedef struct packed {
        lane_t     lane;
        distance_t distance;
    } asteroid_t;

    typedef struct packed {
        lives_t lives;
        score_t score;
    } status_t;

    // control levels, one field per datapath action
    typedef struct packed {
        logic clear_all;       // asteroid, lives and score back to start
        logic spawn;           // load a new asteroid
        logic advance_enable;  // asteroid may move
        logic load_shot;       // latch the shot lane
        logic destroy;         // asteroid was hit
        logic lose_life;
    } control_t;

    typedef enum logic [3:0] {
        idle             = 4'd0,
        init_elements    = 4'd1,
        spawn_asteroid   = 4'd2,
        wait_move        = 4'd3,
        register_shot    = 4'd4,
        compare_shot     = 4'd5,
        destroy_asteroid = 4'd6,
        next_move        = 4'd7,
        lose_life        = 4'd8,
        check_lives      = 4'd9,
        game_over        = 4'd10
    } game_state_e;

endpackage

//--- asteroid_tracker.sv
`timescale 1ns/1ns

module asteroid_tracker #(
    parameter int MAX_DISTANCE = 15,
    parameter int STEP_CYCLES  = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  asteroid_pkg::control_t  control,
    output asteroid_pkg::asteroid_t asteroid,
    output logic                    collision
);

    localparam int STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam asteroid_pkg::distance_t START_DISTANCE =
        asteroid_pkg::distance_t'(MAX_DISTANCE);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(STEP_CYCLES - 1);

    logic [7:0]              lfsr;
    logic [7:0]              lfsr_next;
    logic [STEP_W-1:0]       step_count;
    logic                    step_done;
    logic                    reload;
    asteroid_pkg::lane_t     lane;
    asteroid_pkg::distance_t distance;

    // taps 7,5,4,3
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    assign reload    = control.spawn || control.clear_all;
    assign step_done = control.advance_enable && (step_count == STEP_LAST);

    // lfsr keeps running across games, only a reset reseeds it
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (control.spawn) begin
            lfsr <= lfsr_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lane <= '0;
        end else if (control.spawn) begin
            lane <= lfsr_next[2:0];  // low bits after the shift
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step_count <= '0;
        end else if (reload) begin
            step_count <= '0;
        end else if (control.advance_enable) begin
            if (step_done) begin
                step_count <= '0;
            end else begin
                step_count <= step_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            distance <= START_DISTANCE;
        end else if (reload) begin
            distance <= START_DISTANCE;
        end else if (step_done && distance != '0) begin
            distance <= distance - 1'b1;  // saturates at zero
        end
    end

    assign asteroid  = '{lane: lane, distance: distance};
    assign collision = control.advance_enable && (distance == '0);

endmodule

//--- flist.f
asteroid_pkg.sv
game_control.sv
asteroid_tracker.sv
shot_judge.sv
player_status.sv
asteroid_game.sv
asteroid_game_properties.sv
tb_asteroid_game.sv

//--- game_control.sv
`timescale 1ns/1ns

module game_control (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      shot,
    input  logic                      collision,
    input  logic                      hit,
    input  logic                      lives_left,
    output asteroid_pkg::control_t    control,
    output asteroid_pkg::game_state_e state,
    output logic                      game_over
);

    asteroid_pkg::game_state_e state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= asteroid_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            asteroid_pkg::idle: begin
                if (start) begin
                    state_next = asteroid_pkg::init_elements;
                end
            end
            asteroid_pkg::init_elements: begin
                state_next = asteroid_pkg::spawn_asteroid;
            end
            asteroid_pkg::spawn_asteroid: begin
                state_next = asteroid_pkg::wait_move;
            end
            asteroid_pkg::wait_move: begin
                // shot wins over a collision in the same cycle
                if (shot) begin
                    state_next = asteroid_pkg::register_shot;
                end else if (collision) begin
                    state_next = asteroid_pkg::lose_life;
                end
            end
            asteroid_pkg::register_shot: begin
                state_next = asteroid_pkg::compare_shot;
            end
            asteroid_pkg::compare_shot: begin
                if (hit) begin
                    state_next = asteroid_pkg::destroy_asteroid;
                end else begin
                    state_next = asteroid_pkg::next_move;
                end
            end
            asteroid_pkg::destroy_asteroid: begin
                state_next = asteroid_pkg::spawn_asteroid;
            end
            asteroid_pkg::next_move: begin
                state_next = asteroid_pkg::wait_move;
            end
            asteroid_pkg::lose_life: begin
                state_next = asteroid_pkg::check_lives;
            end
            asteroid_pkg::check_lives: begin
                if (lives_left) begin
                    state_next = asteroid_pkg::spawn_asteroid;
                end else begin
                    state_next = asteroid_pkg::game_over;
                end
            end
            asteroid_pkg::game_over: begin
                if (start) begin
                    state_next = asteroid_pkg::init_elements;
                end
            end
            default: begin
                state_next = asteroid_pkg::idle;
            end
        endcase
    end

    // moore outputs, decoded from the state only
    always_comb begin
        control = '0;
        case (state)
            asteroid_pkg::idle,
            asteroid_pkg::init_elements: begin
                control.clear_all = 1'b1;
            end
            asteroid_pkg::spawn_asteroid: begin
                control.spawn          = 1'b1;
                control.advance_enable = 1'b1;  // timer cleared by spawn anyway
            end
            asteroid_pkg::wait_move: begin
                control.advance_enable = 1'b1;
            end
            asteroid_pkg::register_shot: begin
                control.load_shot      = 1'b1;
                control.advance_enable = 1'b1;
            end
            asteroid_pkg::destroy_asteroid: begin
                control.destroy = 1'b1;
            end
            asteroid_pkg::lose_life: begin
                control.lose_life = 1'b1;
            end
            default: begin
                control = '0;
            end
        endcase
    end

    assign game_over = (state == asteroid_pkg::game_over);

endmodule

//--- player_status.sv
`timescale 1ns/1ns

module player_status #(
    parameter int LIVES_INIT = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  asteroid_pkg::control_t control,
    output asteroid_pkg::status_t  status,
    output logic                   lives_left
);

    localparam asteroid_pkg::lives_t LIVES_START = asteroid_pkg::lives_t'(LIVES_INIT);

    asteroid_pkg::lives_t lives;
    asteroid_pkg::score_t score;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lives <= LIVES_START;
        end else if (control.clear_all) begin
            lives <= LIVES_START;
        end else if (control.lose_life && lives != '0) begin
            lives <= lives - 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (control.clear_all) begin
            score <= '0;
        end else if (control.destroy) begin
            score <= score + 1'b1;  // wraps past 255
        end
    end

    assign status     = '{lives: lives, score: score};
    assign lives_left = (lives != '0);

endmodule

//--- shot_judge.sv
`timescale 1ns/1ns

module shot_judge (
    input  logic                    clock,
    input  logic                    reset,
    input  asteroid_pkg::control_t  control,
    input  asteroid_pkg::lane_t     shot_lane,
    input  asteroid_pkg::asteroid_t asteroid,
    output logic                    hit
);

    asteroid_pkg::lane_t shot_latched;
    logic                lane_match;
    logic                in_range;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shot_latched <= '0;
        end else if (control.load_shot) begin
            shot_latched <= shot_lane;
        end
    end

    assign lane_match = (shot_latched == asteroid.lane);

    // an asteroid already at the ship counts as a collision, not a hit
    assign in_range = (asteroid.distance != '0);

    assign hit = lane_match && in_range;

endmodule

//--- tb_asteroid_game.sv
`timescale 1ns/1ns

module tb_asteroid_game;

    localparam int LIVES_INIT      = 3;
    localparam int MAX_DISTANCE    = 6;
    localparam int STEP_CYCLES     = 4;
    localparam int TEST_ROUNDS     = 10;  // shots plus collisions, rounded up
    localparam int WATCHDOG_CYCLES = 2000 + TEST_ROUNDS * MAX_DISTANCE * STEP_CYCLES;
    localparam int RANDOM_SEED     = 21892;
    localparam logic [7:0] LFSR_SEED = 8'hA5;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      start;
    logic                      shot;
    asteroid_pkg::lane_t       shot_lane;
    asteroid_pkg::asteroid_t   asteroid;
    asteroid_pkg::status_t     status;
    logic                      game_over;
    asteroid_pkg::game_state_e state;

    asteroid_pkg::lives_t exp_lives;
    asteroid_pkg::score_t exp_score;
    asteroid_pkg::lane_t  exp_lane;
    logic                 exp_game_over;
    logic                 checking;
    int                   spawn_count;

    asteroid_game #(
        .LIVES_INIT   (LIVES_INIT),
        .MAX_DISTANCE (MAX_DISTANCE),
        .STEP_CYCLES  (STEP_CYCLES)
    ) asteroid_game_i (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .shot      (shot),
        .shot_lane (shot_lane),
        .asteroid  (asteroid),
        .status    (status),
        .game_over (game_over),
        .state     (state)
    );

    always #2 clock = ~clock;

    // lane of the n-th spawn, lfsr shifted left with taps 7,5,4,3
    function automatic asteroid_pkg::lane_t spawn_lane(input int n);
        logic [7:0] lfsr_model;
        lfsr_model = LFSR_SEED;
        for (int i = 0; i < n; i++) begin
            lfsr_model = {lfsr_model[6:0], ^(lfsr_model & 8'hB8)};
        end
        return lfsr_model[2:0];
    endfunction

    function automatic asteroid_pkg::lane_t other_lane(input asteroid_pkg::lane_t lane);
        return asteroid_pkg::lane_t'(lane + 1 + ($urandom % 7));
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_lane(input string name, input asteroid_pkg::lane_t actual,
                              input asteroid_pkg::lane_t expected);
        if (actual !== expected)
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
    endtask

    task automatic check_distance(input string name, input asteroid_pkg::distance_t actual,
                                  input asteroid_pkg::distance_t expected);
        if (actual !== expected)
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
    endtask

    task automatic check_lives(input string name, input asteroid_pkg::lives_t actual,
                               input asteroid_pkg::lives_t expected);
        if (actual !== expected)
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
    endtask

    task automatic check_score(input string name, input asteroid_pkg::score_t actual,
                               input asteroid_pkg::score_t expected);
        if (actual !== expected)
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
    endtask

    task automatic check_state(input asteroid_pkg::game_state_e expected);
        if (state !== expected)
            report_failure($sformatf("ERROR at %0t ns: state = %s, expected %s",
                                     $time, state.name(), expected.name()));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            report_failure($sformatf("ERROR at %0t ns: %s = %b, expected %b",
                                     $time, name, actual, expected));
    endtask

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // first wait_move cycle after a spawn
    task automatic expect_new_asteroid();
        spawn_count++;
        exp_lane = spawn_lane(spawn_count);
        check_state(asteroid_pkg::wait_move);
        check_lane("asteroid.lane", asteroid.lane, exp_lane);
        check_distance("asteroid.distance", asteroid.distance, MAX_DISTANCE);
    endtask

    task automatic start_game();
        start = 1'b1;
        step();
        start = 1'b0;
        exp_game_over = 1'b0;
        check_state(asteroid_pkg::init_elements);
        step();
        check_state(asteroid_pkg::spawn_asteroid);
        exp_lives = LIVES_INIT;
        exp_score = '0;
        step();
        expect_new_asteroid();
    endtask

    task automatic fire_shot(input asteroid_pkg::lane_t lane);
        logic expect_hit;
        expect_hit = (lane == exp_lane);
        check_state(asteroid_pkg::wait_move);
        shot      = 1'b1;
        shot_lane = lane;
        step();
        shot = 1'b0;
        check_state(asteroid_pkg::register_shot);
        step();
        check_state(asteroid_pkg::compare_shot);
        step();
        if (expect_hit) begin
            check_state(asteroid_pkg::destroy_asteroid);
            step();
            check_state(asteroid_pkg::spawn_asteroid);
            exp_score++;  // 3 edges after the shot edge
            step();
            expect_new_asteroid();
        end else begin
            check_state(asteroid_pkg::next_move);
            step();
            check_state(asteroid_pkg::wait_move);
            check_lane("asteroid.lane", asteroid.lane, exp_lane);
        end
    endtask

    // starts on the first wait_move cycle of a fresh asteroid
    task automatic run_to_collision();
        for (int elapsed = 0; elapsed <= MAX_DISTANCE * STEP_CYCLES; elapsed++) begin
            check_state(asteroid_pkg::wait_move);
            check_distance("asteroid.distance", asteroid.distance,
                           MAX_DISTANCE - elapsed / STEP_CYCLES);
            if (elapsed != MAX_DISTANCE * STEP_CYCLES)
                step();
        end
        step();
        check_state(asteroid_pkg::lose_life);
        step();
        check_state(asteroid_pkg::check_lives);
        exp_lives--;
        step();
        if (exp_lives != '0) begin
            check_state(asteroid_pkg::spawn_asteroid);
            step();
            expect_new_asteroid();
        end else begin
            check_state(asteroid_pkg::game_over);
            exp_game_over = 1'b1;
        end
    endtask

    task automatic hold_without_start(input asteroid_pkg::game_state_e waiting,
                                      input int cycles, input logic with_shots);
        asteroid_pkg::asteroid_t held;
        held = asteroid;
        repeat (cycles) begin
            check_state(waiting);
            check_lane("asteroid.lane", asteroid.lane, held.lane);
            check_distance("asteroid.distance", asteroid.distance, held.distance);
            shot      = with_shots;
            shot_lane = asteroid_pkg::lane_t'($urandom % 8);
            step();
        end
        shot = 1'b0;
        check_state(waiting);
    endtask

    // status compared mid cycle, away from the driving edge
    always @(negedge clock) begin
        if (checking) begin
            check_lives("status.lives", status.lives, exp_lives);
            check_score("status.score", status.score, exp_score);
            check_flag("game_over", game_over, exp_game_over);
            if (asteroid_game_i.asteroid_game_properties_i.failure_count != 0)
                report_failure("a bound assertion on the game control or status failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        report_failure("timeout: the test sequence did not complete in time");
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        reset         = 1'b1;
        start         = 1'b0;
        shot          = 1'b0;
        shot_lane     = '0;
        checking      = 1'b0;
        exp_lives     = LIVES_INIT;
        exp_score     = '0;
        exp_lane      = '0;
        exp_game_over = 1'b0;
        spawn_count   = 0;
        repeat (4) @(posedge clock);
        #1;
        reset    = 1'b0;
        checking = 1'b1;

        hold_without_start(asteroid_pkg::idle, 3 + $urandom % 8, 1'b0);
        start_game();
        fire_shot(exp_lane);
        fire_shot(other_lane(exp_lane));  // miss
        fire_shot(exp_lane);
        repeat (LIVES_INIT) run_to_collision();

        hold_without_start(asteroid_pkg::game_over, 3 + $urandom % 8, 1'b1);
        start_game();  // lfsr carries on from the last game
        fire_shot(exp_lane);
        run_to_collision();

        if (asteroid_game_i.asteroid_game_properties_i.failure_count != 0) begin
            report_failure("a bound assertion on the game control or status failed");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule
